/* source/lampfpu_macros.svh */
// widths for a 16-bit float (1 sign, 8 exponent, 7 fraction); no integer datapath
`ifndef LAMPFPU_MACROS_SVH
`define LAMPFPU_MACROS_SVH

////////////////////
// float format
////////////////////

`define LAMP_FLOAT_DW	16
`define LAMP_FLOAT_E_DW	8
`define LAMP_FLOAT_F_DW	7

////////////////////
// result and control
////////////////////

// compare outcome lives in bit 0, upper bits read as zero
`define LAMP_RESULT_DW	16

// opcode and state encodings are both 2 bits wide
`define LAMP_OPCODE_DW	2
`define LAMP_STATE_DW	2

`endif

/* source/lampfpu_fmt_pkg.sv */
// operand type for the 16-bit float; denormals are flagged as neither zero nor special
`include "lampfpu_macros.svh"

package lampfpu_fmt_pkg;

	////////////////////
	// unpacked operand
	////////////////////

	// raw fields plus class flags, 20 bits total
	typedef struct packed
	{
		logic							sign;
		logic	[`LAMP_FLOAT_E_DW-1:0]	exponent;
		logic	[`LAMP_FLOAT_F_DW-1:0]	fraction;
		// exponent and fraction both zero
		logic							is_zero;
		// exponent all ones, fraction zero
		logic							is_inf;
		// nan with fraction msb clear
		logic							is_snan;
		// nan with fraction msb set
		logic							is_qnan;
	} operand_t;

endpackage

/* source/lampfpu_ctrl_pkg.sv */
// control encodings; only the compare opcodes are supported, FPU_IDLE means no request
`include "lampfpu_macros.svh"

package lampfpu_ctrl_pkg;

	////////////////////
	// opcodes
	////////////////////

	typedef enum logic [`LAMP_OPCODE_DW-1:0]
	{
		FPU_IDLE	= 2'd0,
		FPU_EQ		= 2'd1,
		FPU_LT		= 2'd2,
		FPU_LE		= 2'd3
	} opcode_t;

	////////////////////
	// control fsm states
	////////////////////

	typedef enum logic [`LAMP_STATE_DW-1:0]
	{
		IDLE	= 2'd0,
		WORK	= 2'd1,
		DONE	= 2'd2
	} state_t;

endpackage

/* source/lampfpu_operand_unpack.sv */
// registers and classifies the operand every cycle with no enable; one cycle of latency
`include "lampfpu_macros.svh"

module lampfpu_operand_unpack (
	input	logic								clk,
	input	logic								rst,
	input	logic	[`LAMP_FLOAT_DW-1:0]		op_i,
	output	lampfpu_fmt_pkg::operand_t			operand_o
);

	lampfpu_fmt_pkg::operand_t			operand_next;
	logic	[`LAMP_FLOAT_E_DW-1:0]		exp_field;
	logic	[`LAMP_FLOAT_F_DW-1:0]		frac_field;
	logic								exp_all_ones;
	logic								frac_non_zero;

	////////////////////
	// split and classify
	////////////////////

	always_comb
	begin
		{operand_next.sign, exp_field, frac_field} = op_i;
		exp_all_ones			= &exp_field;
		frac_non_zero			= |frac_field;

		operand_next.exponent	= exp_field;
		operand_next.fraction	= frac_field;
		operand_next.is_zero	= (exp_field == '0) & ~frac_non_zero;
		operand_next.is_inf		= exp_all_ones & ~frac_non_zero;
		// nan flavour picked by the fraction msb
		operand_next.is_snan	= exp_all_ones & frac_non_zero & ~frac_field[`LAMP_FLOAT_F_DW-1];
		operand_next.is_qnan	= exp_all_ones & frac_field[`LAMP_FLOAT_F_DW-1];
	end

	////////////////////
	// output register
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			operand_o	<= '0;
		end
		else
		begin
			operand_o	<= operand_next;
		end
	end

endmodule

/* source/lampfpu_cmp.sv */
// EQ/LT/LE only; any nan gives 0 and no invalid flag is raised; expects a one-cycle start
module lampfpu_cmp (
	input	logic							clk,
	input	logic							rst,
	input	logic							start_i,
	input	lampfpu_ctrl_pkg::opcode_t		opcode_i,
	input	lampfpu_fmt_pkg::operand_t		op_a_i,
	input	lampfpu_fmt_pkg::operand_t		op_b_i,
	output	logic							valid_o,
	output	logic							cmp_o
);

	logic	any_nan;
	logic	both_zero;
	logic	mag_lt;
	logic	mag_gt;
	logic	is_eq;
	logic	is_lt;
	logic	cmp_next;

	////////////////////
	// ordering
	////////////////////

	always_comb
	begin
		any_nan		= op_a_i.is_snan | op_a_i.is_qnan | op_b_i.is_snan | op_b_i.is_qnan;
		both_zero	= op_a_i.is_zero & op_b_i.is_zero;

		// exponent then fraction, same as comparing the concatenation
		mag_lt		= {op_a_i.exponent, op_a_i.fraction} < {op_b_i.exponent, op_b_i.fraction};
		mag_gt		= {op_b_i.exponent, op_b_i.fraction} < {op_a_i.exponent, op_a_i.fraction};

		// +0 and -0 are the same value
		is_eq		= both_zero
			| ((op_a_i.sign == op_b_i.sign)
			& (op_a_i.exponent == op_b_i.exponent)
			& (op_a_i.fraction == op_b_i.fraction));

		if (both_zero)
			is_lt	= 1'b0;
		else if (op_a_i.sign != op_b_i.sign)
			is_lt	= op_a_i.sign;
		else if (op_a_i.sign)
			// negatives: larger magnitude is smaller
			is_lt	= mag_gt;
		else
			is_lt	= mag_lt;

		case (opcode_i)
			lampfpu_ctrl_pkg::FPU_EQ:	cmp_next = is_eq;
			lampfpu_ctrl_pkg::FPU_LT:	cmp_next = is_lt;
			lampfpu_ctrl_pkg::FPU_LE:	cmp_next = is_lt | is_eq;
			default:					cmp_next = 1'b0;
		endcase

		if (any_nan)
			cmp_next	= 1'b0;
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			valid_o	<= 1'b0;
		else
			valid_o	<= start_i;
	end

	always_ff @(posedge clk)
	begin
		if (start_i)
			cmp_o	<= cmp_next;
	end

endmodule

/* source/lampfpu_ctrl.sv */
// one operation in flight; flush_i is only sampled in IDLE and result_o holds after padv_i
`include "lampfpu_macros.svh"

module lampfpu_ctrl (
	input	logic								clk,
	input	logic								rst,
	input	logic								flush_i,
	input	logic								padv_i,
	input	lampfpu_ctrl_pkg::opcode_t			opcode_i,
	input	logic								cmp_valid_i,
	input	logic								cmp_i,
	output	logic								start_o,
	output	lampfpu_ctrl_pkg::opcode_t			opcode_o,
	output	logic	[`LAMP_RESULT_DW-1:0]		result_o,
	output	logic								result_valid_o
);

	lampfpu_ctrl_pkg::state_t			state;
	lampfpu_ctrl_pkg::state_t			state_next;
	logic								start_next;
	lampfpu_ctrl_pkg::opcode_t			opcode_next;
	logic	[`LAMP_RESULT_DW-1:0]		result_next;
	logic								result_valid_next;

	////////////////////
	// next state
	////////////////////

	always_comb
	begin
		state_next			= state;
		start_next			= 1'b0;
		opcode_next			= opcode_o;
		result_next			= result_o;
		result_valid_next	= result_valid_o;

		case (state)
			lampfpu_ctrl_pkg::IDLE:
			begin
				// a flushed request is dropped here
				if (opcode_i != lampfpu_ctrl_pkg::FPU_IDLE && !flush_i)
				begin
					start_next	= 1'b1;
					opcode_next	= opcode_i;
					state_next	= lampfpu_ctrl_pkg::WORK;
				end
			end
			lampfpu_ctrl_pkg::WORK:
			begin
				if (cmp_valid_i)
				begin
					result_next			= {{(`LAMP_RESULT_DW-1){1'b0}}, cmp_i};
					result_valid_next	= 1'b1;
					state_next			= lampfpu_ctrl_pkg::DONE;
				end
			end
			lampfpu_ctrl_pkg::DONE:
			begin
				// result stays put, only the valid drops
				if (padv_i)
				begin
					result_valid_next	= 1'b0;
					state_next			= lampfpu_ctrl_pkg::IDLE;
				end
			end
			default:
			begin
				state_next	= lampfpu_ctrl_pkg::IDLE;
			end
		endcase
	end

	////////////////////
	// registers
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state			<= lampfpu_ctrl_pkg::IDLE;
			start_o			<= 1'b0;
			opcode_o		<= lampfpu_ctrl_pkg::FPU_IDLE;
			result_o		<= '0;
			result_valid_o	<= 1'b0;
		end
		else
		begin
			state			<= state_next;
			start_o			<= start_next;
			opcode_o		<= opcode_next;
			result_o		<= result_next;
			result_valid_o	<= result_valid_next;
		end
	end

endmodule

/* source/lampfpu_top.sv */
// compare-only fpu; result valid 3 edges after acceptance, is_ready_o is combinational
`include "lampfpu_macros.svh"

module lampfpu_top (
	input	logic								clk,
	input	logic								rst,
	input	logic								flush_i,
	input	logic								padv_i,
	input	lampfpu_ctrl_pkg::opcode_t			opcode_i,
	input	logic	[`LAMP_FLOAT_DW-1:0]		op1_i,
	input	logic	[`LAMP_FLOAT_DW-1:0]		op2_i,
	output	logic	[`LAMP_RESULT_DW-1:0]		result_o,
	output	logic								is_result_valid_o,
	output	logic								is_ready_o
);

	lampfpu_fmt_pkg::operand_t		op1_unpacked;
	lampfpu_fmt_pkg::operand_t		op2_unpacked;
	logic							cmp_start;
	lampfpu_ctrl_pkg::opcode_t		cmp_opcode;
	logic							cmp_valid;
	logic							cmp_res;

	////////////////////
	// operand stage
	////////////////////

	lampfpu_operand_unpack unpack_op1 (
		.clk		(clk),
		.rst		(rst),
		.op_i		(op1_i),
		.operand_o	(op1_unpacked)
	);

	lampfpu_operand_unpack unpack_op2 (
		.clk		(clk),
		.rst		(rst),
		.op_i		(op2_i),
		.operand_o	(op2_unpacked)
	);

	////////////////////
	// compare and control
	////////////////////

	lampfpu_cmp cmp (
		.clk		(clk),
		.rst		(rst),
		.start_i	(cmp_start),
		.opcode_i	(cmp_opcode),
		.op_a_i		(op1_unpacked),
		.op_b_i		(op2_unpacked),
		.valid_o	(cmp_valid),
		.cmp_o		(cmp_res)
	);

	lampfpu_ctrl ctrl (
		.clk			(clk),
		.rst			(rst),
		.flush_i		(flush_i),
		.padv_i			(padv_i),
		.opcode_i		(opcode_i),
		.cmp_valid_i	(cmp_valid),
		.cmp_i			(cmp_res),
		.start_o		(cmp_start),
		.opcode_o		(cmp_opcode),
		.result_o		(result_o),
		.result_valid_o	(is_result_valid_o)
	);

	// ready when nothing is requested or a result is waiting for padv_i
	assign is_ready_o = (opcode_i == lampfpu_ctrl_pkg::FPU_IDLE) | is_result_valid_o;

endmodule

/* tb/tb_clk_gen.sv */
// free-running clock for simulation only; starts low, first rising edge at half a period
module tb_clk_gen #(
	parameter int PERIOD = 20
) (
	output	logic	clk_o
);

	////////////////////
	// clock
	////////////////////

	initial
	begin
		clk_o = 1'b0;
	end

	always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* tb/tb_lampfpu_top.sv */
// directed and seeded random tests of the compare-only fpu; inputs change 2 units after rise
`include "lampfpu_macros.svh"

module tb_lampfpu_top;

	// about 185 operations of at most 15 cycles each, plus margin
	localparam int MAX_CYCLES	= 3000;
	localparam int LATENCY		= 3;
	localparam int NUM_DIR		= 14;
	localparam int NUM_NAN		= 4;
	localparam int NUM_RANDOM	= 100;

	// equal values, signed zeros, mixed signs, infinities, then subnormals
	localparam logic [`LAMP_FLOAT_DW-1:0] DIR_A [0:NUM_DIR-1] = '{
		16'h3F80, 16'hBF80, 16'h0000, 16'h8000, 16'hBF80, 16'h3F80, 16'hC000,
		16'h3F80, 16'h7F80, 16'hFF80, 16'h0001, 16'h8001, 16'h0040, 16'h7F80};
	localparam logic [`LAMP_FLOAT_DW-1:0] DIR_B [0:NUM_DIR-1] = '{
		16'h3F80, 16'hBF80, 16'h8000, 16'h0000, 16'h3F80, 16'hBF80, 16'hBF80,
		16'h4000, 16'h4000, 16'hC000, 16'h0040, 16'h0001, 16'h0000, 16'h7F80};
	// two quiet and two signaling nans
	localparam logic [`LAMP_FLOAT_DW-1:0] NAN_VALS [0:NUM_NAN-1] = '{
		16'h7FC0, 16'h7F81, 16'hFFC0, 16'hFFA0};

	logic								clk;
	logic								rst;
	logic								flush_i;
	logic								padv_i;
	lampfpu_ctrl_pkg::opcode_t			opcode_i;
	logic	[`LAMP_FLOAT_DW-1:0]		op1_i;
	logic	[`LAMP_FLOAT_DW-1:0]		op2_i;
	logic	[`LAMP_RESULT_DW-1:0]		result_o;
	logic								is_result_valid_o;
	logic								is_ready_o;

	int			errors	= 0;
	int			ops		= 0;
	int			cycles	= 0;
	integer		seed	= 96156;

	tb_clk_gen #(.PERIOD(20)) clk_gen (.clk_o(clk));

	lampfpu_top dut (
		.clk				(clk),
		.rst				(rst),
		.flush_i			(flush_i),
		.padv_i				(padv_i),
		.opcode_i			(opcode_i),
		.op1_i				(op1_i),
		.op2_i				(op2_i),
		.result_o			(result_o),
		.is_result_valid_o	(is_result_valid_o),
		.is_ready_o			(is_ready_o)
	);

	////////////////////
	// helpers
	////////////////////

	task automatic report_mismatch(input string sig, input int expv, input int gotv);
		errors++;
		$display("ERR %0t %s expected %0h got %0h", $time, sig, expv, gotv);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("at %0t: %s", $time, msg);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	function automatic lampfpu_ctrl_pkg::opcode_t opcode_from_index(input int k);
		case (k)
			0:			return lampfpu_ctrl_pkg::FPU_EQ;
			1:			return lampfpu_ctrl_pkg::FPU_LT;
			default:	return lampfpu_ctrl_pkg::FPU_LE;
		endcase
	endfunction

	// ordering key is the magnitude negated for a negative sign so -0 and +0 meet at 0
	function automatic logic cmp_model(input lampfpu_ctrl_pkg::opcode_t op,
		input logic [`LAMP_FLOAT_DW-1:0] a, input logic [`LAMP_FLOAT_DW-1:0] b);
		int ka;
		int kb;
		logic nan_a;
		logic nan_b;
		nan_a = (&a[`LAMP_FLOAT_DW-2:`LAMP_FLOAT_F_DW]) && (a[`LAMP_FLOAT_F_DW-1:0] != '0);
		nan_b = (&b[`LAMP_FLOAT_DW-2:`LAMP_FLOAT_F_DW]) && (b[`LAMP_FLOAT_F_DW-1:0] != '0);
		if (nan_a || nan_b)
			return 1'b0;
		ka = {17'd0, a[`LAMP_FLOAT_DW-2:0]};
		kb = {17'd0, b[`LAMP_FLOAT_DW-2:0]};
		if (a[`LAMP_FLOAT_DW-1])
			ka = -ka;
		if (b[`LAMP_FLOAT_DW-1])
			kb = -kb;
		case (op)
			lampfpu_ctrl_pkg::FPU_EQ:	return ka == kb;
			lampfpu_ctrl_pkg::FPU_LT:	return ka < kb;
			lampfpu_ctrl_pkg::FPU_LE:	return ka <= kb;
			default:					return 1'b0;
		endcase
	endfunction

	// one request, wait for valid, hold padv_i low for hold cycles, then release
	task automatic run_op(input lampfpu_ctrl_pkg::opcode_t op,
		input logic [`LAMP_FLOAT_DW-1:0] a, input logic [`LAMP_FLOAT_DW-1:0] b, input int hold);
		logic [`LAMP_RESULT_DW-1:0] exp_result;
		int edges;
		int i;
		exp_result = {{(`LAMP_RESULT_DW-1){1'b0}}, cmp_model(op, a, b)};
		ops++;
		opcode_i = op;
		op1_i = a;
		op2_i = b;
		edges = 0;
		while (!is_result_valid_o && edges < 10)
		begin
			next_cycle();
			edges++;
		end
		if (!is_result_valid_o)
			report_failure("no result valid within 10 cycles of the request");
		else
		begin
			if (edges != LATENCY)
				report_mismatch("latency", LATENCY, edges);
			if (result_o !== exp_result)
				report_mismatch("result_o", int'(exp_result), int'(result_o));
			for (i = 0; i < hold; i++)
			begin
				next_cycle();
				if (result_o !== exp_result)
					report_mismatch("result_o", int'(exp_result), int'(result_o));
				if (is_result_valid_o !== 1'b1)
					report_mismatch("is_result_valid_o", 1, int'(is_result_valid_o));
				if (is_ready_o !== 1'b1)
					report_mismatch("is_ready_o", 1, int'(is_ready_o));
			end
		end
		padv_i = 1'b1;
		next_cycle();
		padv_i = 1'b0;
		opcode_i = lampfpu_ctrl_pkg::FPU_IDLE;
		if (is_result_valid_o !== 1'b0)
			report_mismatch("is_result_valid_o", 0, int'(is_result_valid_o));
		if (result_o !== exp_result)
			report_mismatch("result_o", int'(exp_result), int'(result_o));
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_reset();
		int n;
		logic exp_ready;
		for (n = 0; n < 5; n++)
		begin
			next_cycle();
			if (is_result_valid_o !== 1'b0)
				report_mismatch("is_result_valid_o", 0, int'(is_result_valid_o));
			if (result_o !== '0)
				report_mismatch("result_o", 0, int'(result_o));
			// busy opcode during reset is ignored by the fsm
			opcode_i = (n % 2 == 1) ? lampfpu_ctrl_pkg::FPU_LT : lampfpu_ctrl_pkg::FPU_IDLE;
			exp_ready = (n % 2 == 0);
			#1;
			if (is_ready_o !== exp_ready)
				report_mismatch("is_ready_o", int'(exp_ready), int'(is_ready_o));
		end
		rst = 1'b0;
		opcode_i = lampfpu_ctrl_pkg::FPU_IDLE;
		next_cycle();
		if (is_result_valid_o !== 1'b0)
			report_mismatch("is_result_valid_o", 0, int'(is_result_valid_o));
		if (is_ready_o !== 1'b1)
			report_mismatch("is_ready_o", 1, int'(is_ready_o));
	endtask

	task automatic test_directed();
		int n;
		int k;
		for (n = 0; n < NUM_DIR; n++)
			for (k = 0; k < 3; k++)
				run_op(opcode_from_index(k), DIR_A[n], DIR_B[n], 0);
	endtask

	task automatic test_nan();
		int n;
		int k;
		for (n = 0; n < NUM_NAN; n++)
			for (k = 0; k < 3; k++)
			begin
				run_op(opcode_from_index(k), NAN_VALS[n], 16'h3F80, 0);
				run_op(opcode_from_index(k), 16'hBF80, NAN_VALS[n], 0);
				// identical bit patterns would read as equal without nan handling
				run_op(opcode_from_index(k), NAN_VALS[n], NAN_VALS[n], 0);
			end
	endtask

	task automatic test_backpressure();
		int h;
		for (h = 0; h <= 6; h++)
			run_op(lampfpu_ctrl_pkg::FPU_LE, DIR_A[h], DIR_B[h], h);
	endtask

	task automatic test_flush();
		int n;
		opcode_i = lampfpu_ctrl_pkg::FPU_LT;
		op1_i = 16'h3F80;
		op2_i = 16'h4000;
		flush_i = 1'b1;
		for (n = 0; n < 6; n++)
		begin
			next_cycle();
			if (is_result_valid_o)
				report_failure("result valid appeared after a flushed request");
		end
		flush_i = 1'b0;
		opcode_i = lampfpu_ctrl_pkg::FPU_IDLE;
		next_cycle();
		run_op(lampfpu_ctrl_pkg::FPU_LT, 16'hBF80, 16'h3F80, 0);
	endtask

	task automatic test_random();
		int n;
		logic [31:0] rnd;
		logic [31:0] sel;
		logic [`LAMP_FLOAT_DW-1:0] a;
		logic [`LAMP_FLOAT_DW-1:0] b;
		for (n = 0; n < NUM_RANDOM; n++)
		begin
			rnd = $random(seed);
			sel = $random(seed);
			a = rnd[`LAMP_FLOAT_DW-1:0];
			b = rnd[31:32-`LAMP_FLOAT_DW];
			// equal pairs now and then so EQ sees hits
			if (sel[8])
				b = a;
			run_op(opcode_from_index(int'(sel % 32'd3)), a, b, 0);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial
	begin
		rst = 1'b1;
		flush_i = 1'b0;
		padv_i = 1'b0;
		opcode_i = lampfpu_ctrl_pkg::FPU_IDLE;
		op1_i = '0;
		op2_i = '0;
		test_reset();
		test_directed();
		test_nan();
		test_backpressure();
		test_flush();
		test_random();
		$display("summary: %0d errors over %0d operations", errors, ops);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run exceeded %0d cycles", MAX_CYCLES);
			$display("summary: %0d errors over %0d operations", errors, ops);
			$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

/* filelist.f */
+incdir+source
source/lampfpu_fmt_pkg.sv
source/lampfpu_ctrl_pkg.sv
source/lampfpu_operand_unpack.sv
source/lampfpu_cmp.sv
source/lampfpu_ctrl.sv
source/lampfpu_top.sv
tb/tb_clk_gen.sv
tb/tb_lampfpu_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator; exit status follows the pass message in sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary -f filelist.f --top-module tb_lampfpu_top -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or run failed"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
